// File: hdl/prf_pkg.sv
/*
 * sizes, index types and request structs for the banked register file
 * imported by every design module and by the testbench
 */

package prf_pkg;

    // --------------------
    // sizes
    localparam int PR_COUNT        = 64;
    localparam int BANK_COUNT      = 4;
    localparam int LOG_PR_COUNT    = 6;
    localparam int LOG_BANK_COUNT  = 2;
    localparam int UPPER_PR_W      = LOG_PR_COUNT - LOG_BANK_COUNT;
    localparam int LOG_ROB_ENTRIES = 6;
    localparam int READ_PORTS      = 2;

    // --------------------
    // index and value types

    // low LOG_BANK_COUNT bits pick the bank
    typedef logic [LOG_PR_COUNT-1:0]    pr_t;
    typedef logic [UPPER_PR_W-1:0]      upper_pr_t;
    typedef logic [31:0]                word_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;

    // --------------------
    // request and bus structs
    typedef struct packed {
        pr_t pr;
    } rd_req_t;

    typedef struct packed {
        pr_t      pr;
        word_t    data;
        rob_idx_t rob_index;
    } wb_req_t;

    typedef struct packed {
        logic      valid;
        upper_pr_t upper_pr;
    } wb_bus_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_index;
    } complete_bus_t;

endpackage

// File: hdl/prf_bank_arbiter.sv
/*
 * per-bank rotating arbiter with one held request per requester
 * used for both the read ports and the writeback port of the register file
 */

`timescale 1ns/1ps

module prf_bank_arbiter #(
    parameter int  NUM_REQ    = 4,
    parameter int  NUM_GRANTS = 2,
    parameter type payload_t  = prf_pkg::rd_req_t
) (
    input  logic                                                CLK,
    input  logic                                                nRST,

    // requesters
    input  logic     [NUM_REQ-1:0]                              req_valid,
    input  payload_t [NUM_REQ-1:0]                              req,
    output logic     [NUM_REQ-1:0]                              ready,
    output logic     [NUM_REQ-1:0]                              ack,
    output logic     [NUM_REQ-1:0]                              ack_port,

    // grants by bank
    output logic     [prf_pkg::BANK_COUNT-1:0][NUM_GRANTS-1:0]  grant_valid,
    output payload_t [prf_pkg::BANK_COUNT-1:0][NUM_GRANTS-1:0]  grant_payload
);

    import prf_pkg::*;

    // --------------------
    // signals

    // one held request per requester
    logic     [NUM_REQ-1:0]                         held_valid;
    payload_t [NUM_REQ-1:0]                         held_req;

    // held request wins over a new one
    logic     [NUM_REQ-1:0]                         cand_valid;
    payload_t [NUM_REQ-1:0]                         cand_req;
    logic     [BANK_COUNT-1:0][NUM_REQ-1:0]         cand_by_bank;

    // bits above the previous winner of each bank
    logic     [BANK_COUNT-1:0][NUM_REQ-1:0]         last_mask;
    logic     [BANK_COUNT-1:0][NUM_REQ-1:0]         next_last_mask;

    logic     [BANK_COUNT-1:0][NUM_GRANTS-1:0]      next_grant_valid;
    payload_t [BANK_COUNT-1:0][NUM_GRANTS-1:0]      next_grant_payload;
    logic     [NUM_REQ-1:0]                         next_ack;
    logic     [NUM_REQ-1:0]                         next_ack_port;

    // isolate the lowest set bit
    function automatic logic [NUM_REQ-1:0] lowest_one(input logic [NUM_REQ-1:0] vec);
        return vec & (~vec + NUM_REQ'(1));
    endfunction

    // --------------------
    // merge and steer to banks
    always_comb begin
        cand_by_bank = '0;
        for (int r = 0; r < NUM_REQ; r++) begin
            cand_valid[r] = held_valid[r] | req_valid[r];
            cand_req[r]   = held_valid[r] ? held_req[r] : req[r];
            cand_by_bank[cand_req[r].pr[LOG_BANK_COUNT-1:0]][r] = cand_valid[r];
        end
    end

    // --------------------
    // grant selection
    always_comb begin
        logic [NUM_REQ-1:0] avail;
        logic [NUM_REQ-1:0] masked;
        logic [NUM_REQ-1:0] pick;
        logic [NUM_REQ-1:0] granted;
        logic               seen;

        next_ack           = '0;
        next_ack_port      = '0;
        next_grant_valid   = '0;
        next_grant_payload = '0;
        next_last_mask     = last_mask;

        for (int b = 0; b < BANK_COUNT; b++) begin
            avail   = cand_by_bank[b];
            granted = '0;

            // grant g goes to port g, earlier winners drop out
            for (int g = 0; g < NUM_GRANTS; g++) begin
                masked = avail & last_mask[b];
                pick   = (|masked) ? lowest_one(masked) : lowest_one(avail);
                avail   = avail & ~pick;
                granted = granted | pick;
                next_grant_valid[b][g] = |pick;
                for (int r = 0; r < NUM_REQ; r++) begin
                    if (pick[r]) begin
                        next_grant_payload[b][g] = cand_req[r];
                        next_ack_port[r]         = (g != 0);
                    end
                end
            end

            next_ack = next_ack | granted;

            // mask moves past the highest granted index
            seen = 1'b0;
            if (|granted) begin
                for (int r = NUM_REQ - 1; r >= 0; r--) begin
                    seen = seen | granted[r];
                    next_last_mask[b][r] = ~seen;
                end
            end
        end
    end

    // --------------------
    // registers
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid    <= '0;
            last_mask     <= '0;
            ack           <= '0;
            ack_port      <= '0;
            grant_valid   <= '0;
            grant_payload <= '0;
        end else begin
            held_valid    <= cand_valid & ~next_ack;
            last_mask     <= next_last_mask;
            ack           <= next_ack;
            ack_port      <= next_ack_port;
            grant_valid   <= next_grant_valid;
            grant_payload <= next_grant_payload;
        end
    end

    // payload of a losing request, read only while held_valid is set
    always_ff @(posedge CLK) begin
        held_req <= cand_req;
    end

    assign ready = ~held_valid;

    // every grant belongs to its own requester
    a_grant_per_ack : assert property (@(posedge CLK) disable iff (!nRST)
        $countones(ack) == $countones(grant_valid));

    // an ack needs a request from the cycle before
    for (genvar r = 0; r < NUM_REQ; r++) begin : g_ack_chk
        a_ack_has_req : assert property (@(posedge CLK) disable iff (!nRST)
            ack[r] |-> $past(held_valid[r] | req_valid[r]));
    end

endmodule

// File: hdl/prf_bank_ram.sv
/*
 * storage for one bank of the register file
 * two asynchronous read ports, one write port taken on the rising edge
 */

`timescale 1ns/1ps

module prf_bank_ram (
    input  logic                                                CLK,
    input  logic                                                nRST,

    // read ports
    input  prf_pkg::upper_pr_t [prf_pkg::READ_PORTS-1:0]        rd_index,
    output prf_pkg::word_t     [prf_pkg::READ_PORTS-1:0]        rd_data,

    // write port
    input  logic                                                wr_en,
    input  prf_pkg::upper_pr_t                                  wr_index,
    input  prf_pkg::word_t                                      wr_data
);

    import prf_pkg::*;

    localparam int DEPTH = PR_COUNT / BANK_COUNT;

    word_t mem [DEPTH];

    // write at the end of the cycle, so a read in the same cycle sees the old word
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // --------------------
    // asynchronous reads
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_data[p] = mem[rd_index[p]];
        end
    end

endmodule

// File: hdl/prf_wb_stage.sv
/*
 * result stage for writeback grants
 * drives the array write, the writeback and complete buses and forward data
 */

`timescale 1ns/1ps

module prf_wb_stage (
    input  logic                                                CLK,
    input  logic                                                nRST,

    // registered writeback grants by bank
    input  logic               [prf_pkg::BANK_COUNT-1:0]        grant_valid,
    input  prf_pkg::wb_req_t   [prf_pkg::BANK_COUNT-1:0]        grant,

    // array write by bank
    output logic               [prf_pkg::BANK_COUNT-1:0]        wr_en,
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]        wr_index,
    output prf_pkg::word_t     [prf_pkg::BANK_COUNT-1:0]        wr_data,

    // result buses by bank
    output prf_pkg::wb_bus_t       [prf_pkg::BANK_COUNT-1:0]    wb_bus,
    output prf_pkg::complete_bus_t [prf_pkg::BANK_COUNT-1:0]    complete_bus,
    output prf_pkg::word_t         [prf_pkg::BANK_COUNT-1:0]    forward_data
);

    import prf_pkg::*;

    // only bank 0 can hold register 0
    logic [BANK_COUNT-1:0] is_zero_reg;

    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            is_zero_reg[b] = (grant[b].pr == '0);

            // register 0 stays zero and is never advertised
            wr_en[b]    = grant_valid[b] & ~is_zero_reg[b];
            wr_index[b] = grant[b].pr[LOG_PR_COUNT-1:LOG_BANK_COUNT];
            wr_data[b]  = grant[b].data;

            wb_bus[b].valid    = wr_en[b];
            wb_bus[b].upper_pr = wr_index[b];

            // completion goes out for every writeback
            complete_bus[b].valid     = grant_valid[b];
            complete_bus[b].rob_index = grant[b].rob_index;
        end
    end

    // --------------------
    // forward data, one cycle after the write
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            forward_data <= '0;
        end else begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (grant_valid[b]) begin
                    forward_data[b] <= grant[b].data;
                end
            end
        end
    end

    a_no_zero_write : assert property (@(posedge CLK) disable iff (!nRST)
        !(wr_en[0] && wr_index[0] == '0));

endmodule

// File: hdl/prf_top.sv
/*
 * banked physical register file, 64 registers in 4 banks
 * read and writeback arbiters feed the bank arrays and the result stage
 */

`timescale 1ns/1ps

module prf_top #(
    parameter int RR_COUNT = 4,
    parameter int WR_COUNT = 3
) (
    input  logic                                                        CLK,
    input  logic                                                        nRST,

    // read requesters
    input  logic               [RR_COUNT-1:0]                           rd_req_valid,
    input  prf_pkg::rd_req_t   [RR_COUNT-1:0]                           rd_req,
    output logic               [RR_COUNT-1:0]                           rd_ready,
    output logic               [RR_COUNT-1:0]                           rd_ack,
    output logic               [RR_COUNT-1:0]                           rd_ack_port,

    // read data by bank and port
    output prf_pkg::word_t [prf_pkg::BANK_COUNT-1:0][prf_pkg::READ_PORTS-1:0] read_data,

    // writeback requesters
    input  logic               [WR_COUNT-1:0]                           wb_valid,
    input  prf_pkg::wb_req_t   [WR_COUNT-1:0]                           wb_req,
    output logic               [WR_COUNT-1:0]                           wb_ready,

    // result buses by bank
    output prf_pkg::wb_bus_t       [prf_pkg::BANK_COUNT-1:0]            wb_bus,
    output prf_pkg::complete_bus_t [prf_pkg::BANK_COUNT-1:0]            complete_bus,
    output prf_pkg::word_t         [prf_pkg::BANK_COUNT-1:0]            forward_data
);

    import prf_pkg::*;

    // --------------------
    // internal wires

    // read grants, port index matches grant index
    rd_req_t   [BANK_COUNT-1:0][READ_PORTS-1:0]     rd_grant;

    // one writeback grant per bank
    logic      [BANK_COUNT-1:0]                     wb_grant_valid;
    wb_req_t   [BANK_COUNT-1:0]                     wb_grant;

    // array write by bank
    logic      [BANK_COUNT-1:0]                     wr_en;
    upper_pr_t [BANK_COUNT-1:0]                     wr_index;
    word_t     [BANK_COUNT-1:0]                     wr_data;

    // --------------------
    // arbiters
    prf_bank_arbiter #(
        .NUM_REQ    (RR_COUNT),
        .NUM_GRANTS (READ_PORTS),
        .payload_t  (rd_req_t)
    ) u_rd_arb (
        .CLK            (CLK),
        .nRST           (nRST),
        .req_valid      (rd_req_valid),
        .req            (rd_req),
        .ready          (rd_ready),
        .ack            (rd_ack),
        .ack_port       (rd_ack_port),
        .grant_valid    (),
        .grant_payload  (rd_grant)
    );

    // writebacks see their ack through wb_ready
    prf_bank_arbiter #(
        .NUM_REQ    (WR_COUNT),
        .NUM_GRANTS (1),
        .payload_t  (wb_req_t)
    ) u_wb_arb (
        .CLK            (CLK),
        .nRST           (nRST),
        .req_valid      (wb_valid),
        .req            (wb_req),
        .ready          (wb_ready),
        .ack            (),
        .ack_port       (),
        .grant_valid    (wb_grant_valid),
        .grant_payload  (wb_grant)
    );

    // --------------------
    // result stage
    prf_wb_stage u_wb_stage (
        .CLK            (CLK),
        .nRST           (nRST),
        .grant_valid    (wb_grant_valid),
        .grant          (wb_grant),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_data        (wr_data),
        .wb_bus         (wb_bus),
        .complete_bus   (complete_bus),
        .forward_data   (forward_data)
    );

    // --------------------
    // bank arrays
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        upper_pr_t [READ_PORTS-1:0] rd_index;

        // drop the bank bits from the granted register
        for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
            assign rd_index[p] = rd_grant[b][p].pr[LOG_PR_COUNT-1:LOG_BANK_COUNT];
        end

        prf_bank_ram u_bank_ram (
            .CLK        (CLK),
            .nRST       (nRST),
            .rd_index   (rd_index),
            .rd_data    (read_data[b]),
            .wr_en      (wr_en[b]),
            .wr_index   (wr_index[b]),
            .wr_data    (wr_data[b])
        );
    end

endmodule

// File: include/prf_tb_model.svh
/*
 * register contents model for the register file testbench
 * included in the testbench module body after the prf_pkg import
 */

`ifndef PRF_TB_MODEL_SVH
`define PRF_TB_MODEL_SVH

// one word per physical register
word_t model_mem [PR_COUNT];

function automatic void model_clear();
    for (int i = 0; i < PR_COUNT; i++) begin
        model_mem[i] = '0;
    end
endfunction

// register 0 never changes
function automatic void model_write(input pr_t pr, input word_t data);
    if (pr != '0) begin
        model_mem[pr] = data;
    end
endfunction

// value that a read of pr must return
function automatic word_t expect_read(input pr_t pr);
    return model_mem[pr];
endfunction

`endif

// File: bench/prf_tb.sv
/*
 * testbench for the banked register file
 * drives requests on the falling edge, checks reads and result buses against a model
 */

`timescale 1ns/1ps

module prf_tb;

    import prf_pkg::*;

    localparam int RR_COUNT      = 4;
    localparam int WR_COUNT      = 3;
    localparam int RANDOM_CYCLES = 400;
    // summed nominal test lengths in cycles
    localparam int TEST_CYCLES   = 3 * PR_COUNT + 8 + RR_COUNT + WR_COUNT + RANDOM_CYCLES;

    logic                                           CLK;
    logic                                           nRST;
    logic          [RR_COUNT-1:0]                   rd_req_valid;
    rd_req_t       [RR_COUNT-1:0]                   rd_req;
    logic          [RR_COUNT-1:0]                   rd_ready;
    logic          [RR_COUNT-1:0]                   rd_ack;
    logic          [RR_COUNT-1:0]                   rd_ack_port;
    word_t         [BANK_COUNT-1:0][READ_PORTS-1:0] read_data;
    logic          [WR_COUNT-1:0]                   wb_valid;
    wb_req_t       [WR_COUNT-1:0]                   wb_req;
    logic          [WR_COUNT-1:0]                   wb_ready;
    wb_bus_t       [BANK_COUNT-1:0]                 wb_bus;
    complete_bus_t [BANK_COUNT-1:0]                 complete_bus;
    word_t         [BANK_COUNT-1:0]                 forward_data;

    // requests taken by the DUT and not yet answered
    logic          [RR_COUNT-1:0]                   rd_pending;
    pr_t                                            rd_pend_pr [RR_COUNT];
    logic                                           wb_live [1 << LOG_ROB_ENTRIES];
    wb_req_t                                        wb_sent [1 << LOG_ROB_ENTRIES];
    int                                             wb_outstanding;
    rob_idx_t                                       rob_next;
    // forward data expected one cycle after a completion
    logic          [BANK_COUNT-1:0]                 fwd_due;
    word_t         [BANK_COUNT-1:0]                 fwd_val;
    int                                             error_count;
    int                                             test_count;
    int                                             errors_before;

    `include "prf_tb_model.svh"

    prf_top #(.RR_COUNT(RR_COUNT), .WR_COUNT(WR_COUNT)) u_prf_top (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // --------------------
    // checks and report
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR %s", what);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %-22s %0d errors", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    // --------------------
    // stimulus
    task automatic issue_wb(input int w, input pr_t pr, input word_t data);
        wb_valid[w]            = 1'b1;
        wb_req[w].pr           = pr;
        wb_req[w].data         = data;
        wb_req[w].rob_index    = rob_next;
        rob_next               = rob_next + 1'b1;
    endtask

    // drop all requests and wait until every taken one is answered
    task automatic drain();
        @(negedge CLK);
        rd_req_valid = '0;
        wb_valid     = '0;
        wait (rd_pending == '0 && wb_outstanding == 0);
    endtask

    task automatic read_reg(input pr_t pr);
        @(negedge CLK);
        rd_req_valid[0] = 1'b1;
        rd_req[0].pr    = pr;
        drain();
    endtask

    task automatic write_reg(input int w, input pr_t pr, input word_t data);
        @(negedge CLK);
        issue_wb(w, pr, data);
        drain();
    endtask

    // requests are taken at the rising edge while ready is high
    always @(posedge CLK) begin
        for (int r = 0; r < RR_COUNT; r++) begin
            if (nRST && rd_req_valid[r] && rd_ready[r]) begin
                rd_pending[r] = 1'b1;
                rd_pend_pr[r] = rd_req[r].pr;
            end
        end
        for (int w = 0; w < WR_COUNT; w++) begin
            if (nRST && wb_valid[w] && wb_ready[w]) begin
                wb_live[wb_req[w].rob_index] = 1'b1;
                wb_sent[wb_req[w].rob_index] = wb_req[w];
                wb_outstanding++;
            end
        end
    end

    // --------------------
    // compare process, reads see the model before this cycle's writes
    always @(negedge CLK) begin
        logic [BANK_COUNT-1:0][READ_PORTS-1:0] port_used;
        int                                    bank;
        rob_idx_t                              rob;
        wb_req_t                               wr;

        port_used = '0;
        if (nRST) begin
            for (int r = 0; r < RR_COUNT; r++) begin
                bank = rd_pend_pr[r] % BANK_COUNT;
                if (rd_ack[r]) begin
                    check_true(rd_pending[r] && !port_used[bank][rd_ack_port[r]],
                               $sformatf("stray or doubled read ack for requester %0d", r));
                    check_value($sformatf("read_data[%0d][%0d]", bank, rd_ack_port[r]),
                                read_data[bank][rd_ack_port[r]], expect_read(rd_pend_pr[r]));
                    port_used[bank][rd_ack_port[r]] = 1'b1;
                    rd_pending[r] = 1'b0;
                end else if (rd_pending[r]) begin
                    check_true(!rd_ready[r], $sformatf("rd_ready high while read %0d is held", r));
                end
            end
            for (int b = 0; b < BANK_COUNT; b++) begin
                rob = complete_bus[b].rob_index;
                wr  = wb_sent[rob];
                if (fwd_due[b]) begin
                    check_value($sformatf("forward_data[%0d]", b), forward_data[b], fwd_val[b]);
                end
                fwd_due[b] = complete_bus[b].valid;
                fwd_val[b] = wr.data;
                check_true(complete_bus[b].valid || !wb_bus[b].valid,
                           $sformatf("wb_bus valid without a completion on bank %0d", b));
                if (complete_bus[b].valid) begin
                    check_true(wb_live[rob] && wr.pr % BANK_COUNT == b,
                               $sformatf("completion on bank %0d for unknown ROB index %h", b, rob));
                    // register 0 completes but is never advertised
                    check_value($sformatf("wb_bus[%0d].valid", b), wb_bus[b].valid, wr.pr != 0);
                    if (wr.pr != 0) begin
                        check_value($sformatf("wb_bus[%0d].upper_pr", b), wb_bus[b].upper_pr,
                                    wr.pr / BANK_COUNT);
                    end
                    if (wb_live[rob]) begin
                        model_write(wr.pr, wr.data);
                        wb_live[rob] = 1'b0;
                        wb_outstanding--;
                    end
                end
            end
        end
    end

    // --------------------
    // tests
    initial begin
        void'($urandom(75));
        nRST = 1'b0;
        {rd_req_valid, rd_req, wb_valid, wb_req} = '0;
        {rd_pending, fwd_due, fwd_val, rob_next} = '0;
        {error_count, test_count, errors_before, wb_outstanding} = '0;
        wb_live = '{default: 1'b0};
        model_clear();
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        @(negedge CLK);
        check_value("rd_ack", rd_ack, '0);
        check_value("rd_ready", rd_ready, {RR_COUNT{1'b1}});
        check_value("wb_ready", wb_ready, {WR_COUNT{1'b1}});
        for (int b = 0; b < BANK_COUNT; b++) begin
            check_value($sformatf("wb_bus[%0d].valid", b), wb_bus[b].valid, 1'b0);
            check_value($sformatf("complete_bus[%0d].valid", b), complete_bus[b].valid, 1'b0);
        end
        for (int i = 0; i < PR_COUNT; i++) begin
            read_reg(pr_t'(i));
        end
        end_test("reset");

        for (int i = 1; i < PR_COUNT; i++) begin
            write_reg(i % WR_COUNT, pr_t'(i), $urandom);
            read_reg(pr_t'(i));
        end
        end_test("write then read");

        write_reg(0, '0, 32'hdead_beef);
        read_reg('0);
        end_test("register zero");

        // all read requesters aim at bank 1
        @(negedge CLK);
        for (int r = 0; r < RR_COUNT; r++) begin
            rd_req_valid[r] = 1'b1;
            rd_req[r].pr    = pr_t'(BANK_COUNT * (r + 1) + 1);
        end
        drain();
        end_test("read contention");

        // all writebacks aim at bank 2, two of them at one register
        @(negedge CLK);
        for (int w = 0; w < WR_COUNT; w++) begin
            issue_wb(w, pr_t'(BANK_COUNT * (w % 2 + 1) + 2), $urandom);
        end
        drain();
        for (int u = 0; u < PR_COUNT / BANK_COUNT; u++) begin
            read_reg(pr_t'(BANK_COUNT * u + 2));
        end
        end_test("writeback contention");

        repeat (RANDOM_CYCLES) begin
            @(negedge CLK);
            for (int r = 0; r < RR_COUNT; r++) begin
                rd_req_valid[r] = rd_ready[r] && ($urandom % 2 == 0);
                rd_req[r].pr    = pr_t'($urandom);
            end
            for (int w = 0; w < WR_COUNT; w++) begin
                wb_valid[w] = 1'b0;
                if (wb_ready[w] && $urandom % 3 == 0) begin
                    issue_wb(w, pr_t'($urandom), $urandom);
                end
            end
        end
        drain();
        end_test("random mix");

        $display("%0d tests, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog, 20 cycles per nominal test cycle
    initial begin
        repeat (TEST_CYCLES * 20) @(posedge CLK);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES * 20);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
hdl/prf_pkg.sv
hdl/prf_bank_arbiter.sv
hdl/prf_bank_ram.sv
hdl/prf_wb_stage.sv
hdl/prf_top.sv
bench/prf_tb.sv
